//--- flist.f
+incdir+source
source/pet_bus_pkg.sv
source/ram_slot_if.sv
source/frame_sequencer.sv
source/wb_request_stage.sv
source/ram_access_stage.sv
source/cpu_bus_gate.sv
source/pet_bus_top.sv
test/sram_model.sv
test/pet_bus_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the PET bus core testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module pet_bus_tb -Mdir obj_dir -f flist.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vpet_bus_tb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "No errors"; then
    exit 0
fi
exit 1

//--- test/pet_bus_tb.sv
// Testbench for the PET bus core, drives Wishbone and CPU traffic and checks it with assertions
`timescale 1ns/1ps
`include "pet_bus_macros.svh"

module pet_bus_tb;

    localparam int CLK_PERIOD      = 4;
    localparam int RESET_CYCLES    = 3;
    localparam int CPU_FRAMES      = 6;  // Frames of CPU traffic only
    localparam int WATCHDOG_FRAMES = 40; // About twice what all phases need

    typedef struct packed {
        pet_bus_pkg::ram_addr_t addr;
        pet_bus_pkg::bus_data_t data;
        logic                   we;
    } wb_req_t;

    logic                   wb_clock_i;
    logic                   rst_n_i;
    pet_bus_pkg::ram_addr_t wb_addr_i;
    pet_bus_pkg::bus_data_t wb_data_i;
    pet_bus_pkg::bus_data_t wb_data_o;
    logic                   wb_we_i;
    logic                   wb_cyc_i;
    logic                   wb_stb_i;
    logic                   wb_stall_o;
    logic                   wb_ack_o;
    logic                   cpu_be_o;
    logic                   cpu_clock_o;
    pet_bus_pkg::cpu_addr_t cpu_addr_i;
    pet_bus_pkg::cpu_addr_t cpu_addr_o;
    logic                   cpu_addr_oe_o;
    logic                   cpu_we_i;
    logic                   cpu_we_o;
    logic                   cpu_we_oe_o;
    pet_bus_pkg::ram_addr_t ram_addr_o;
    logic                   ram_oe_o;
    logic                   ram_we_o;
    pet_bus_pkg::bus_data_t ram_data_i;
    pet_bus_pkg::bus_data_t ram_data_o;
    logic                   ram_data_oe_o;
    logic                   io_oe_o;
    logic                   pia1_cs_o;
    logic                   pia2_cs_o;
    logic                   via_cs_o;
    pet_bus_pkg::bus_data_t cpu_data; // Byte the CPU puts on a write

    wb_req_t                pending[$];     // Accepted, not yet acknowledged
    pet_bus_pkg::bus_data_t ref_mem[pet_bus_pkg::ram_addr_t];
    pet_bus_pkg::ram_addr_t cpu_written[$]; // RAM addresses the CPU wrote
    string                  test_name;
    int ctrl_errors;
    int decode_errors;
    int data_errors;
    int reads_checked;

    // Frame trackers, all counted from the DUT pins
    int   since_rst;
    int   be_len;   // Samples with BE high so far in this CPU cycle
    int   phi_len;
    int   rise_gap; // Cycles since the last Phi2 rise
    logic rise_seen;
    logic phi_q;

    logic       cpu_io_hit;
    logic       cpu_rd_exp;
    logic       cpu_wr_exp;
    logic       quiet;
    logic [3:0] decode_exp;

    pet_bus_top pet_bus_top_inst (.*);

    sram_model sram_model_inst (
        .clk_i        (wb_clock_i),
        .addr_i       (ram_addr_o),
        .oe_i         (ram_oe_o),
        .we_i         (ram_we_o),
        .dut_data_oe_i(ram_data_oe_o),
        .dut_data_i   (ram_data_o),
        .cpu_data_i   (cpu_data),
        .data_o       (ram_data_i)
    );

    function automatic logic in_block(input pet_bus_pkg::cpu_addr_t addr,
                                      input pet_bus_pkg::cpu_addr_t base, input int size);
        return (int'(addr) >= int'(base)) && (int'(addr) < int'(base) + size);
    endfunction

    // Biased toward the I/O page so every select gets hit
    function automatic pet_bus_pkg::cpu_addr_t pick_cpu_addr();
        pet_bus_pkg::cpu_addr_t r;
        r = pet_bus_pkg::cpu_addr_t'($urandom);
        case ($urandom_range(0, 4))
            0: return `PET_IO_BASE | {8'h00, r[7:0]};
            1: return `PET_PIA1_BASE | {12'h000, r[3:0]};
            2: return `PET_PIA2_BASE | {12'h000, r[3:0]};
            3: return `PET_VIA_BASE | {12'h000, r[3:0]};
            default: return r;
        endcase
    endfunction

    // Expected pins from the memory map and the slot macros
    assign cpu_io_hit = in_block(cpu_addr_i, `PET_IO_BASE, 256);
    assign decode_exp = {cpu_io_hit, in_block(cpu_addr_i, `PET_PIA1_BASE, 16),
                         in_block(cpu_addr_i, `PET_PIA2_BASE, 16),
                         in_block(cpu_addr_i, `PET_VIA_BASE, 16)} & {4{cpu_be_o}};
    assign cpu_rd_exp = cpu_be_o && !cpu_io_hit && !cpu_we_i
                        && be_len >= `PET_RD_START - `PET_BE_START
                        && be_len < `PET_PHI_END - `PET_BE_START;
    assign cpu_wr_exp = cpu_be_o && !cpu_io_hit && cpu_we_i
                        && be_len >= `PET_PHI_START - `PET_BE_START
                        && be_len < `PET_PHI_END - `PET_BE_START;
    assign quiet      = !rst_n_i || since_rst <= `PET_BE_START; // Before the first BE

    initial begin
        wb_clock_i = 1'b0;
        forever #(CLK_PERIOD / 2) wb_clock_i = ~wb_clock_i;
    end

    always @(posedge wb_clock_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            since_rst <= 0;
            be_len    <= 0;
            phi_len   <= 0;
            rise_gap  <= 0;
            rise_seen <= 1'b0;
            phi_q     <= 1'b0;
        end else begin
            since_rst <= since_rst + 1;
            be_len    <= cpu_be_o ? be_len + 1 : 0;
            phi_len   <= cpu_clock_o ? phi_len + 1 : 0;
            rise_gap  <= (cpu_clock_o && !phi_q) ? 1 : rise_gap + 1;
            rise_seen <= rise_seen | (cpu_clock_o & ~phi_q);
            phi_q     <= cpu_clock_o;
        end
    end

    // New CPU cycle set up only while the core owns the bus
    always @(negedge wb_clock_i) begin
        if (!cpu_be_o) begin
            cpu_addr_i <= pick_cpu_addr();
            cpu_we_i   <= 1'($urandom_range(0, 1));
            cpu_data   <= pet_bus_pkg::bus_data_t'($urandom);
        end
    end

    // Reference memory and scoreboard, sampled mid-cycle
    always @(negedge wb_clock_i) begin
        wb_req_t req;
        if (rst_n_i && cpu_wr_exp) begin
            ref_mem[{1'b0, cpu_addr_i}] = cpu_data;
            if (be_len == `PET_PHI_START - `PET_BE_START) begin
                cpu_written.push_back({1'b0, cpu_addr_i}); // Once per CPU write
            end
        end
        // Strobe outside BE belongs to the oldest outstanding request
        if (rst_n_i && !cpu_be_o && (ram_oe_o || ram_we_o)) begin
            if (pending.size() == 0) begin
                data_errors++;
                $display("RAM strobed outside a CPU cycle with no request outstanding at %0t",
                         $time);
            end else begin
                req = pending[0];
                assert (ram_addr_o == req.addr)
                else begin
                    data_errors++;
                    $display("Fail %s: ram_addr_o expected %h actual %h", test_name,
                             req.addr, ram_addr_o);
                end
                assert (cpu_addr_o == req.addr[`PET_CPU_ADDR_W-1:0])
                else begin
                    data_errors++;
                    $display("Fail %s: cpu_addr_o expected %h actual %h", test_name,
                             req.addr[`PET_CPU_ADDR_W-1:0], cpu_addr_o);
                end
            end
        end
        if (rst_n_i && wb_ack_o) begin
            if (pending.size() == 0) begin
                data_errors++;
                $display("wb_ack_o pulsed with no request outstanding at %0t", $time);
            end else begin
                req = pending.pop_front(); // Acks come back in request order
                if (req.we) begin
                    ref_mem[req.addr] = req.data;
                end else if (ref_mem.exists(req.addr)) begin
                    reads_checked++;
                    assert (wb_data_o == ref_mem[req.addr])
                    else begin
                        data_errors++;
                        $display("Fail %s: read %h expected %h actual %h", test_name,
                                 req.addr, ref_mem[req.addr], wb_data_o);
                    end
                end
            end
        end
    end

    reset_quiet: assert property (@(posedge wb_clock_i) quiet |-> !cpu_be_o && !cpu_clock_o
        && !cpu_we_o && !cpu_we_oe_o && !wb_ack_o && wb_stall_o && !ram_oe_o && !ram_we_o
        && !ram_data_oe_o && !io_oe_o && !pia1_cs_o && !pia2_cs_o && !via_cs_o)
        else begin
            ctrl_errors++;
            $display("A control output was active during or right after reset at %0t", $time);
        end

    be_owns_bus: assert property (@(posedge wb_clock_i) disable iff (!rst_n_i)
        cpu_be_o |-> wb_stall_o && !cpu_addr_oe_o && ram_addr_o == {1'b0, cpu_addr_i})
        else begin
            ctrl_errors++;
            $display("Wishbone side kept the bus while cpu_be_o was high at %0t", $time);
        end

    // Any strobe beyond the CPU's own would be a Wishbone access
    be_strobes: assert property (@(posedge wb_clock_i) disable iff (!rst_n_i)
        cpu_be_o |-> ram_oe_o == cpu_rd_exp && ram_we_o == cpu_wr_exp)
        else begin
            ctrl_errors++;
            $display("Fail %s: oe/we in CPU cycle expected %b%b actual %b%b", test_name,
                     $sampled(cpu_rd_exp), $sampled(cpu_wr_exp),
                     $sampled(ram_oe_o), $sampled(ram_we_o));
        end

    phi_in_be: assert property (@(posedge wb_clock_i) disable iff (!rst_n_i)
        cpu_clock_o |-> cpu_be_o)
        else begin
            ctrl_errors++;
            $display("cpu_clock_o was high outside cpu_be_o at %0t", $time);
        end

    phi_width: assert property (@(posedge wb_clock_i) disable iff (!rst_n_i)
        $fell(cpu_clock_o) |-> phi_len == `PET_PHI_END - `PET_PHI_START)
        else begin
            ctrl_errors++;
            $display("Fail %s: cpu_clock_o high cycles expected %0d actual %0d", test_name,
                     `PET_PHI_END - `PET_PHI_START, $sampled(phi_len));
        end

    phi_period: assert property (@(posedge wb_clock_i) disable iff (!rst_n_i)
        $rose(cpu_clock_o) && rise_seen |-> rise_gap == `PET_FRAME_CYCLES)
        else begin
            ctrl_errors++;
            $display("Fail %s: cpu_clock_o period expected %0d actual %0d", test_name,
                     `PET_FRAME_CYCLES, $sampled(rise_gap));
        end

    be_width: assert property (@(posedge wb_clock_i) disable iff (!rst_n_i)
        $fell(cpu_be_o) |-> be_len == `PET_BE_END - `PET_BE_START)
        else begin
            ctrl_errors++;
            $display("Fail %s: cpu_be_o high cycles expected %0d actual %0d", test_name,
                     `PET_BE_END - `PET_BE_START, $sampled(be_len));
        end

    io_decode: assert property (@(posedge wb_clock_i) disable iff (!rst_n_i)
        {io_oe_o, pia1_cs_o, pia2_cs_o, via_cs_o} == decode_exp)
        else begin
            decode_errors++;
            $display("Fail %s: selects for %h expected %b actual %b", test_name,
                     $sampled(cpu_addr_i), $sampled(decode_exp),
                     $sampled({io_oe_o, pia1_cs_o, pia2_cs_o, via_cs_o}));
        end

    io_no_ram: assert property (@(posedge wb_clock_i) disable iff (!rst_n_i)
        cpu_be_o && cpu_io_hit |-> !ram_oe_o && !ram_we_o)
        else begin
            decode_errors++;
            $display("RAM strobed for I/O address %h at %0t", $sampled(cpu_addr_i), $time);
        end

    // Holds the request until a negedge sees stall low, the next edge accepts it
    task automatic wb_issue(input pet_bus_pkg::ram_addr_t addr, input logic we,
                            input pet_bus_pkg::bus_data_t data);
        wb_req_t req;
        @(negedge wb_clock_i);
        wb_cyc_i  = 1'b1;
        wb_stb_i  = 1'b1;
        wb_addr_i = addr;
        wb_we_i   = we;
        wb_data_i = data;
        while (wb_stall_o) @(negedge wb_clock_i);
        req.addr = addr;
        req.data = data;
        req.we   = we;
        pending.push_back(req);
    endtask

    task automatic wb_finish();
        @(negedge wb_clock_i);
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
        while (pending.size() != 0) @(negedge wb_clock_i); // Cycle stays open for the acks
        wb_cyc_i = 1'b0;
    endtask

    initial begin
        int i;
        int j;
        int n;
        pet_bus_pkg::ram_addr_t addr;
        pet_bus_pkg::bus_data_t data;
        void'($urandom(32'h8bd9));
        rst_n_i       = 1'b0;
        wb_addr_i     = '0;
        wb_data_i     = '0;
        wb_we_i       = 1'b0;
        wb_cyc_i      = 1'b0;
        wb_stb_i      = 1'b0;
        cpu_addr_i    = '0;
        cpu_we_i      = 1'b0;
        cpu_data      = '0;
        ctrl_errors   = 0;
        decode_errors = 0;
        data_errors   = 0;
        reads_checked = 0;
        test_name     = "reset";
        repeat (RESET_CYCLES) @(negedge wb_clock_i);
        rst_n_i = 1'b1;

        // Write then read back each address, several bursts
        test_name = "wb_burst";
        for (i = 0; i < 4; i++) begin
            n = $urandom_range(3, 6);
            for (j = 0; j < n; j++) begin
                addr = pet_bus_pkg::ram_addr_t'($urandom);
                data = pet_bus_pkg::bus_data_t'($urandom);
                wb_issue(addr, 1'b1, data);
                wb_issue(addr, 1'b0, '0);
            end
            wb_finish();
        end

        test_name = "cpu_cycles";
        repeat (CPU_FRAMES * `PET_FRAME_CYCLES) @(negedge wb_clock_i);

        test_name = "cpu_readback";
        n = cpu_written.size();
        if (n == 0) begin
            data_errors++;
            $display("No CPU write reached the RAM, nothing to read back");
        end
        for (i = 0; i < n; i++) begin
            wb_issue(cpu_written[i], 1'b0, '0);
        end
        wb_finish();
        repeat (`PET_FRAME_CYCLES) @(negedge wb_clock_i);

        if (reads_checked == 0) begin
            data_errors++;
            $display("No Wishbone read was compared against the reference");
        end
        $display("Reads compared %0d, control errors %0d, decode errors %0d, data errors %0d",
                 reads_checked, ctrl_errors, decode_errors, data_errors);
        if (ctrl_errors + decode_errors + data_errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_FRAMES * `PET_FRAME_CYCLES * CLK_PERIOD);
        $display("Watchdog expired before the tests finished, stuck in %s", test_name);
        $display("Errors found");
        $finish;
    end

endmodule

//--- test/sram_model.sv
// Behavioral 128K x 8 SRAM for the testbench, the CPU data bus is merged onto its data input
`timescale 1ns/1ps

module sram_model (
    input  logic                   clk_i,         // Only used to time the write sample
    input  pet_bus_pkg::ram_addr_t addr_i,
    input  logic                   oe_i,
    input  logic                   we_i,
    input  logic                   dut_data_oe_i, // Core drives the data pins
    input  pet_bus_pkg::bus_data_t dut_data_i,
    input  pet_bus_pkg::bus_data_t cpu_data_i,    // Data from the modeled CPU
    output pet_bus_pkg::bus_data_t data_o
);

    localparam int DEPTH = 1 << 17;

    pet_bus_pkg::bus_data_t mem [DEPTH];
    pet_bus_pkg::bus_data_t write_data;

    // Fill pattern mixes all 17 address bits
    initial begin
        for (int a = 0; a < DEPTH; a++) begin
            mem[a] = a[7:0] ^ a[15:8] ^ {7'b0, a[16]};
        end
    end

    // Core write data wins, otherwise the CPU owns the data bus
    assign write_data = dut_data_oe_i ? dut_data_i : cpu_data_i;

    // Write sampled mid-cycle, address and strobe are settled there
    always @(negedge clk_i) begin
        if (we_i) begin
            mem[addr_i] <= write_data;
        end
    end

    assign data_o = oe_i ? mem[addr_i] : '0; // Pins float without OE, read back as zero

endmodule

//--- source/pet_bus_top.sv
// Top level of the PET bus-sharing core, CPU frame slots plus a pipelined Wishbone SRAM master
`timescale 1ns/1ps

module pet_bus_top (
    input  logic                   wb_clock_i,
    input  logic                   rst_n_i,

    // Wishbone B4 pipelined
    input  pet_bus_pkg::ram_addr_t wb_addr_i,
    input  pet_bus_pkg::bus_data_t wb_data_i,
    output pet_bus_pkg::bus_data_t wb_data_o,
    input  logic                   wb_we_i,
    input  logic                   wb_cyc_i,
    input  logic                   wb_stb_i,
    output logic                   wb_stall_o,
    output logic                   wb_ack_o,

    // CPU
    output logic                   cpu_be_o,
    output logic                   cpu_clock_o,  // Phi2
    input  pet_bus_pkg::cpu_addr_t cpu_addr_i,
    output pet_bus_pkg::cpu_addr_t cpu_addr_o,
    output logic                   cpu_addr_oe_o,
    input  logic                   cpu_we_i,
    output logic                   cpu_we_o,
    output logic                   cpu_we_oe_o,

    // RAM
    output pet_bus_pkg::ram_addr_t ram_addr_o,
    output logic                   ram_oe_o,
    output logic                   ram_we_o,
    input  pet_bus_pkg::bus_data_t ram_data_i,
    output pet_bus_pkg::bus_data_t ram_data_o,
    output logic                   ram_data_oe_o,

    // I/O
    output logic                   io_oe_o,
    output logic                   pia1_cs_o,
    output logic                   pia2_cs_o,
    output logic                   via_cs_o
);

    logic                   rd_window;
    logic                   wr_window;
    logic                   wb_window;
    pet_bus_pkg::ram_addr_t wb_ram_addr; // RAM stage address before the pin mux
    logic                   wb_ram_oe;
    logic                   wb_ram_we;

    ram_slot_if slot_if ();

    frame_sequencer frame_sequencer_inst (
        .wb_clock_i (wb_clock_i),
        .rst_n_i    (rst_n_i),
        .cpu_be_o   (cpu_be_o),
        .phi2_o     (cpu_clock_o),
        .rd_window_o(rd_window),
        .wr_window_o(wr_window),
        .wb_window_o(wb_window)
    );

    wb_request_stage wb_request_stage_inst (
        .wb_clock_i (wb_clock_i),
        .rst_n_i    (rst_n_i),
        .wb_addr_i  (wb_addr_i),
        .wb_data_i  (wb_data_i),
        .wb_we_i    (wb_we_i),
        .wb_cyc_i   (wb_cyc_i),
        .wb_stb_i   (wb_stb_i),
        .wb_window_i(wb_window),
        .wb_stall_o (wb_stall_o),
        .slot       (slot_if.src)
    );

    ram_access_stage ram_access_stage_inst (
        .wb_clock_i   (wb_clock_i),
        .rst_n_i      (rst_n_i),
        .slot         (slot_if.dst),
        .ram_data_i   (ram_data_i),
        .ram_addr_o   (wb_ram_addr),
        .ram_oe_o     (wb_ram_oe),
        .ram_we_o     (wb_ram_we),
        .ram_data_o   (ram_data_o),
        .ram_data_oe_o(ram_data_oe_o),
        .wb_data_o    (wb_data_o),
        .wb_ack_o     (wb_ack_o)
    );

    cpu_bus_gate cpu_bus_gate_inst (
        .cpu_addr_i   (cpu_addr_i),
        .cpu_we_i     (cpu_we_i),
        .cpu_be_i     (cpu_be_o),
        .rd_window_i  (rd_window),
        .wr_window_i  (wr_window),
        .wb_ram_addr_i(wb_ram_addr),
        .wb_ram_oe_i  (wb_ram_oe),
        .wb_ram_we_i  (wb_ram_we),
        .ram_addr_o   (ram_addr_o),
        .ram_oe_o     (ram_oe_o),
        .ram_we_o     (ram_we_o),
        .cpu_addr_o   (cpu_addr_o),
        .cpu_addr_oe_o(cpu_addr_oe_o),
        .io_oe_o      (io_oe_o),
        .pia1_cs_o    (pia1_cs_o),
        .pia2_cs_o    (pia2_cs_o),
        .via_cs_o     (via_cs_o)
    );

    // RWB driven low only inside the Wishbone window, released after reset
    assign cpu_we_o    = 1'b0;
    assign cpu_we_oe_o = cpu_addr_oe_o & wb_window;

endmodule

//--- source/cpu_bus_gate.sv
// PET address decoder and pin mux that merges CPU and Wishbone strobes onto the RAM and I/O pins
`timescale 1ns/1ps
`include "pet_bus_macros.svh"

module cpu_bus_gate (
    input  pet_bus_pkg::cpu_addr_t cpu_addr_i,
    input  logic                   cpu_we_i,      // High for a CPU write
    input  logic                   cpu_be_i,
    input  logic                   rd_window_i,
    input  logic                   wr_window_i,
    input  pet_bus_pkg::ram_addr_t wb_ram_addr_i,
    input  logic                   wb_ram_oe_i,
    input  logic                   wb_ram_we_i,
    output pet_bus_pkg::ram_addr_t ram_addr_o,
    output logic                   ram_oe_o,
    output logic                   ram_we_o,
    output pet_bus_pkg::cpu_addr_t cpu_addr_o,
    output logic                   cpu_addr_oe_o,
    output logic                   io_oe_o,
    output logic                   pia1_cs_o,
    output logic                   pia2_cs_o,
    output logic                   via_cs_o
);

    logic io_hit;
    logic ram_hit;

    assign io_hit  = (cpu_addr_i & `PET_IO_MASK) == `PET_IO_BASE;
    assign ram_hit = ~io_hit; // No holes in the map

    // Selects only while the CPU owns the bus
    assign io_oe_o   = io_hit & cpu_be_i;
    assign pia1_cs_o = ((cpu_addr_i & `PET_REG_MASK) == `PET_PIA1_BASE) & cpu_be_i;
    assign pia2_cs_o = ((cpu_addr_i & `PET_REG_MASK) == `PET_PIA2_BASE) & cpu_be_i;
    assign via_cs_o  = ((cpu_addr_i & `PET_REG_MASK) == `PET_VIA_BASE) & cpu_be_i;

    // Wishbone strobes never overlap BE, so a plain OR is enough
    assign ram_oe_o = (ram_hit & cpu_be_i & rd_window_i & ~cpu_we_i) | wb_ram_oe_i;
    assign ram_we_o = (ram_hit & cpu_be_i & wr_window_i & cpu_we_i) | wb_ram_we_i;

    // CPU sees the lower 64 KiB only
    assign ram_addr_o = cpu_be_i ? {1'b0, cpu_addr_i} : wb_ram_addr_i;

    // Wishbone address driven onto the CPU bus while the CPU is parked
    assign cpu_addr_o    = wb_ram_addr_i[`PET_CPU_ADDR_W-1:0];
    assign cpu_addr_oe_o = ~cpu_be_i;

endmodule

//--- source/ram_access_stage.sv
// SRAM access engine, runs one timed access per slot item and returns ack and read data
`timescale 1ns/1ps

module ram_access_stage (
    input  logic                   wb_clock_i,
    input  logic                   rst_n_i,
    ram_slot_if.dst                slot,
    input  pet_bus_pkg::bus_data_t ram_data_i,
    output pet_bus_pkg::ram_addr_t ram_addr_o,
    output logic                   ram_oe_o,
    output logic                   ram_we_o,
    output pet_bus_pkg::bus_data_t ram_data_o,
    output logic                   ram_data_oe_o,
    output pet_bus_pkg::bus_data_t wb_data_o,
    output logic                   wb_ack_o
);

    pet_bus_pkg::ram_phase_e state;
    logic                    we_q; // Latched direction

    assign slot.ready = (state == pet_bus_pkg::IDLE);

    // Strobes decoded from the phase, address and data come from the latches
    assign ram_oe_o      = (state == pet_bus_pkg::STROBE) & ~we_q;
    assign ram_we_o      = (state == pet_bus_pkg::STROBE) & we_q;
    assign ram_data_oe_o = (state != pet_bus_pkg::IDLE) & we_q; // SETUP through DONE

    always_ff @(posedge wb_clock_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state    <= pet_bus_pkg::IDLE;
            wb_ack_o <= 1'b0;
        end else begin
            wb_ack_o <= 1'b0; // Single cycle pulse
            case (state)
                pet_bus_pkg::IDLE: begin
                    if (slot.valid) begin
                        state <= pet_bus_pkg::SETUP;
                    end
                end
                pet_bus_pkg::SETUP:  state <= pet_bus_pkg::STROBE;
                pet_bus_pkg::STROBE: state <= pet_bus_pkg::DONE;
                pet_bus_pkg::DONE: begin
                    wb_ack_o <= 1'b1; // Rises 4 cycles after the Wishbone accept
                    state    <= pet_bus_pkg::IDLE;
                end
                default: state <= pet_bus_pkg::IDLE;
            endcase
        end
    end

    // Item latched on the transfer edge, held steady for the whole access
    always_ff @(posedge wb_clock_i) begin
        if (slot.valid && slot.ready) begin
            ram_addr_o <= slot.addr;
            ram_data_o <= slot.wdata;
            we_q       <= slot.we;
        end
    end

    // Read data sampled as OE closes, it stays put through the ack
    always_ff @(posedge wb_clock_i) begin
        if (ram_oe_o) begin
            wb_data_o <= ram_data_i;
        end
    end

endmodule

//--- source/wb_request_stage.sv
// Wishbone pipelined slave front end, accepts requests in the Wishbone window into the slot
`timescale 1ns/1ps

module wb_request_stage (
    input  logic                   wb_clock_i,
    input  logic                   rst_n_i,
    input  pet_bus_pkg::ram_addr_t wb_addr_i,
    input  pet_bus_pkg::bus_data_t wb_data_i,
    input  logic                   wb_we_i,
    input  logic                   wb_cyc_i,
    input  logic                   wb_stb_i,
    input  logic                   wb_window_i, // From the frame sequencer
    output logic                   wb_stall_o,
    ram_slot_if.src                slot
);

    logic full;     // Request register holds an item
    logic window_q; // Window delayed by one cycle
    logic accept;
    logic drain;

    // A request taken on the last window edge may still be handed on one cycle later,
    // its strobe then ends before BE rises. Later than that the item waits for the next window
    assign slot.valid = full & (wb_window_i | window_q);
    assign drain      = slot.valid & slot.ready;

    assign wb_stall_o = ~wb_window_i | (full & ~drain); // Empty or emptying this edge
    assign accept     = wb_cyc_i & wb_stb_i & ~wb_stall_o;

    always_ff @(posedge wb_clock_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            full     <= 1'b0;
            window_q <= 1'b0;
        end else begin
            window_q <= wb_window_i;
            if (accept) begin
                full <= 1'b1; // Also covers accept while draining
            end else if (drain) begin
                full <= 1'b0;
            end
        end
    end

    // Request payload
    always_ff @(posedge wb_clock_i) begin
        if (accept) begin
            slot.addr  <= wb_addr_i;
            slot.wdata <= wb_data_i;
            slot.we    <= wb_we_i;
        end
    end

endmodule

//--- source/frame_sequencer.sv
// Frame counter that times the CPU bus enable, Phi2, RAM windows and the Wishbone window
`timescale 1ns/1ps
`include "pet_bus_macros.svh"

module frame_sequencer (
    input  logic wb_clock_i,
    input  logic rst_n_i,
    output logic cpu_be_o,    // CPU owns the bus
    output logic phi2_o,      // CPU clock
    output logic rd_window_o, // RAM may drive the CPU data bus
    output logic wr_window_o, // CPU write data is valid
    output logic wb_window_o  // Wishbone may start accesses
);

    pet_bus_pkg::frame_count_t count;

    // Free-running, wraps once per frame
    always_ff @(posedge wb_clock_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            count <= '0;
        end else if (count == pet_bus_pkg::frame_count_t'(`PET_FRAME_CYCLES - 1)) begin
            count <= '0;
        end else begin
            count <= count + 1'b1;
        end
    end

    // Each window edge lands one cycle after its slot value
    always_ff @(posedge wb_clock_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cpu_be_o    <= 1'b0;
            phi2_o      <= 1'b0;
            rd_window_o <= 1'b0;
            wr_window_o <= 1'b0;
            wb_window_o <= 1'b0; // Closed until the first WB_OPEN slot
        end else begin
            case (count)
                pet_bus_pkg::frame_count_t'(`PET_WB_CLOSE): wb_window_o <= 1'b0;
                pet_bus_pkg::frame_count_t'(`PET_BE_START): cpu_be_o    <= 1'b1;
                pet_bus_pkg::frame_count_t'(`PET_RD_START): rd_window_o <= 1'b1;
                pet_bus_pkg::frame_count_t'(`PET_PHI_START): begin
                    phi2_o      <= 1'b1;
                    wr_window_o <= 1'b1; // Write strobe rides on Phi2 high
                end
                pet_bus_pkg::frame_count_t'(`PET_PHI_END): begin
                    phi2_o      <= 1'b0;
                    wr_window_o <= 1'b0;
                    rd_window_o <= 1'b0; // Read data held through the falling edge
                end
                pet_bus_pkg::frame_count_t'(`PET_BE_END): cpu_be_o    <= 1'b0;
                pet_bus_pkg::frame_count_t'(`PET_WB_OPEN): wb_window_o <= 1'b1;
                default: begin
                end
            endcase
        end
    end

endmodule

//--- source/ram_slot_if.sv
// Handshake carrying one accepted Wishbone request from the request stage to the RAM stage
`timescale 1ns/1ps

interface ram_slot_if;

    logic                  valid; // Item on the slot
    logic                  ready; // RAM stage idle
    pet_bus_pkg::ram_addr_t addr;
    pet_bus_pkg::bus_data_t wdata;
    logic                  we;    // High for a write

    // Request stage side
    modport src (
        output valid, addr, wdata, we,
        input  ready
    );

    // RAM access stage side
    modport dst (
        input  valid, addr, wdata, we,
        output ready
    );

endinterface

//--- source/pet_bus_pkg.sv
// Vector types and the RAM access state enum shared by the bus core, used by scoped name
`include "pet_bus_macros.svh"

package pet_bus_pkg;

    // Address as seen on the 6502 pins
    typedef logic [`PET_CPU_ADDR_W-1:0] cpu_addr_t;

    // Full SRAM address, bit 16 only reachable from Wishbone
    typedef logic [`PET_RAM_ADDR_W-1:0] ram_addr_t;

    typedef logic [`PET_DATA_W-1:0] bus_data_t; // One data byte

    // Position inside the frame
    typedef logic [$clog2(`PET_FRAME_CYCLES)-1:0] frame_count_t;

    // Phases of one SRAM access
    typedef enum logic [1:0] {
        IDLE,   // Waiting for a slot item, ready high
        SETUP,  // Address and write data settle
        STROBE, // OE or WE pulse
        DONE    // Strobe released, ack follows
    } ram_phase_e;

endpackage

//--- source/pet_bus_macros.svh
// Frame slot positions, bus widths and PET memory map bounds, included by the RTL and the testbench
`ifndef PET_BUS_MACROS_SVH
`define PET_BUS_MACROS_SVH

// Bus widths fixed by the PET hardware
`define PET_CPU_ADDR_W 16 // 6502 address bus
`define PET_RAM_ADDR_W 17 // 128 KiB SRAM
`define PET_DATA_W     8

`define PET_FRAME_CYCLES 64 // One CPU cycle per frame, so 1 MHz Phi2 from 64 MHz

// Slot values in wb_clock_i cycles of 15.625 ns
// Each W65C02 delay is rounded up to whole cycles, plus one cycle for propagation
`define PET_WB_CLOSE  0  // Wishbone stops accepting, leaves 3 cycles to drain
`define PET_BE_START  3  // BE raised once the last Wishbone strobe is over
`define PET_RD_START  6  // tBVD 30 ns gives 2 + 1 cycles after BE
`define PET_PHI_START 9  // tAA 10 ns plus tDSR 15 ns gives 2 + 1 cycles
`define PET_PHI_END   15 // tPWH 62 ns gives 4 cycles, 2 more kept as slack
`define PET_BE_END    17 // tDHR and tDHW 10 ns give 1 + 1 cycles
`define PET_WB_OPEN   20 // tBVD again, CPU pins back in high-Z

// Memory map, every CPU address outside the I/O page is RAM
`define PET_IO_MASK   16'hFF00 // Compare the page only
`define PET_REG_MASK  16'hFFF0 // Compare down to a 16 byte register block
`define PET_IO_BASE   16'hE800 // E800 to E8FF
`define PET_PIA1_BASE 16'hE810 // E810 to E81F
`define PET_PIA2_BASE 16'hE820 // E820 to E82F
`define PET_VIA_BASE  16'hE840 // E840 to E84F

`endif
